//--- common/ooo_settings.svh
`ifndef OOO_SETTINGS_SVH
`define OOO_SETTINGS_SVH

// Superscalar widths
`define NUM_SUPER 2
`define NUM_ISSUE 2

// Station, tag and ROB sizes
`define NUM_RS    8
`define NUM_PR    32
`define NUM_ROB   16

// Field widths
`define FU_KIND_W 2
`define FUNC_W    4

// FU kind per station entry, entry NUM_RS-1 first in the list.
// Each lane (even entries, odd entries) holds every kind.
// Entries 0..7 are ALU ALU MUL MEM ALU ALU MEM MUL.
`define RS_KIND_LIST {FU_MUL, FU_MEM, FU_ALU, FU_ALU, FU_MEM, FU_MUL, FU_ALU, FU_ALU}

`endif

//--- common/ooo_types_pkg.sv
`include "ooo_settings.svh"

package ooo_types_pkg;

  // Physical register tag
  typedef logic [$clog2(`NUM_PR)-1:0] pr_tag_t;

  // ROB slot index
  typedef logic [$clog2(`NUM_ROB)-1:0] rob_idx_t;

  // Station entry index
  typedef logic [$clog2(`NUM_RS)-1:0] rs_idx_t;

  // Functional unit kind and operation code
  typedef logic [`FU_KIND_W-1:0] fu_kind_t;
  typedef logic [`FUNC_W-1:0] func_t;

  localparam fu_kind_t FU_ALU = 2'd0;
  localparam fu_kind_t FU_MUL = 2'd1;
  localparam fu_kind_t FU_MEM = 2'd2;

  // Zero register, always ready
  localparam pr_tag_t ZERO_TAG = '0;

endpackage

//--- common/ooo_ctrl_pkg.sv
package ooo_ctrl_pkg;

  // Dispatch gating states
  typedef enum logic [1:0] {
    CTRL_INIT,   // First cycle out of reset
    CTRL_RUN,    // Dispatch allowed
    CTRL_SQUASH  // Cycle after a rollback
  } ctrl_state_t;

endpackage

//--- logic/dispatch_ctrl.sv
`timescale 1ns/1ps
`include "ooo_settings.svh"

module dispatch_ctrl (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   dispatch_req,
  input  logic [`NUM_SUPER-1:0]  slot_hit,
  input  logic                   rollback_en,
  output logic                   dispatch_fire
);

  import ooo_ctrl_pkg::*;

  ctrl_state_t state;
  ctrl_state_t state_next;

  always_comb begin
    state_next = state;
    case (state)
      CTRL_INIT:   state_next = rollback_en ? CTRL_SQUASH : CTRL_RUN;
      CTRL_RUN:    if (rollback_en) state_next = CTRL_SQUASH;
      CTRL_SQUASH: state_next = rollback_en ? CTRL_SQUASH : CTRL_RUN;  // Back-to-back rollback
      default:     state_next = CTRL_INIT;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset)
      state <= CTRL_INIT;
    else
      state <= state_next;
  end

  // All-or-nothing for the group; rollback cycle itself is blocked too
  assign dispatch_fire = dispatch_req && (&slot_hit) && state == CTRL_RUN && !rollback_en;

  // The requester keeps its group until it is taken
  req_held_until_ack: assert property (@(posedge clock) disable iff (reset)
    dispatch_req && !dispatch_fire |=> dispatch_req);

endmodule

//--- logic/tag_scoreboard.sv
`timescale 1ns/1ps
`include "ooo_settings.svh"

module tag_scoreboard (
  input  logic                                      clock,
  input  logic                                      reset,
  input  logic                                      dispatch_fire,
  input  ooo_types_pkg::pr_tag_t [`NUM_SUPER-1:0]   disp_dest,
  input  ooo_types_pkg::pr_tag_t [`NUM_SUPER-1:0]   disp_src1,
  input  ooo_types_pkg::pr_tag_t [`NUM_SUPER-1:0]   disp_src2,
  input  logic                   [`NUM_SUPER-1:0]   complete_en,
  input  ooo_types_pkg::pr_tag_t [`NUM_SUPER-1:0]   complete_tag,
  output logic                   [`NUM_SUPER-1:0]   src1_ready,
  output logic                   [`NUM_SUPER-1:0]   src2_ready
);

  import ooo_types_pkg::*;

  logic [`NUM_PR-1:0] tag_ready;  // One bit per physical tag

  // Stored bit, same-cycle completion, then an older slot's dest in this group
  function automatic logic src_is_ready(pr_tag_t src, int slot);
    logic rdy;
    rdy = (src == ZERO_TAG) || tag_ready[src];
    for (int c = 0; c < `NUM_SUPER; c++) begin
      if (complete_en[c] && complete_tag[c] == src)
        rdy = 1'b1;  // Bypass
    end
    for (int k = 0; k < slot; k++) begin
      if (disp_dest[k] == src && src != ZERO_TAG)
        rdy = 1'b0;  // Produced inside this group
    end
    return rdy;
  endfunction

  always_comb begin
    for (int s = 0; s < `NUM_SUPER; s++) begin
      src1_ready[s] = src_is_ready(disp_src1[s], s);
      src2_ready[s] = src_is_ready(disp_src2[s], s);
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      tag_ready <= '1;
    end else begin
      for (int c = 0; c < `NUM_SUPER; c++) begin
        if (complete_en[c])
          tag_ready[complete_tag[c]] <= 1'b1;
      end
      if (dispatch_fire) begin
        for (int s = 0; s < `NUM_SUPER; s++) begin
          if (disp_dest[s] != ZERO_TAG)
            tag_ready[disp_dest[s]] <= 1'b0;  // Now in flight
        end
      end
    end
  end

  // The zero register never completes
  for (genvar c = 0; c < `NUM_SUPER; c++) begin : g_cdb_chk
    no_zero_complete: assert property (@(posedge clock) disable iff (reset)
      complete_en[c] |-> complete_tag[c] != ZERO_TAG);
  end

endmodule

//--- rs/rs_station.sv
`timescale 1ns/1ps
`include "ooo_settings.svh"

module rs_station (
  input  logic                                         clock,
  input  logic                                         reset,
  input  logic                                         dispatch_fire,
  input  ooo_types_pkg::fu_kind_t [`NUM_SUPER-1:0]     disp_kind,
  input  ooo_types_pkg::func_t    [`NUM_SUPER-1:0]     disp_func,
  input  ooo_types_pkg::pr_tag_t  [`NUM_SUPER-1:0]     disp_dest,
  input  ooo_types_pkg::pr_tag_t  [`NUM_SUPER-1:0]     disp_src1,
  input  ooo_types_pkg::pr_tag_t  [`NUM_SUPER-1:0]     disp_src2,
  input  ooo_types_pkg::rob_idx_t [`NUM_SUPER-1:0]     disp_rob,
  input  logic                    [`NUM_SUPER-1:0]     src1_ready,
  input  logic                    [`NUM_SUPER-1:0]     src2_ready,
  input  logic                    [`NUM_SUPER-1:0]     complete_en,
  input  ooo_types_pkg::pr_tag_t  [`NUM_SUPER-1:0]     complete_tag,
  input  logic                                         rollback_en,
  input  ooo_types_pkg::rob_idx_t                      rollback_rob,
  input  ooo_types_pkg::rob_idx_t                      rollback_span,
  input  logic                    [`NUM_RS-1:0]        pick_mask,
  output logic                    [`NUM_SUPER-1:0]     slot_hit,
  output logic                    [`NUM_RS-1:0]        entry_eligible,
  output ooo_types_pkg::func_t    [`NUM_RS-1:0]        entry_func,
  output ooo_types_pkg::pr_tag_t  [`NUM_RS-1:0]        entry_dest,
  output ooo_types_pkg::rob_idx_t [`NUM_RS-1:0]        entry_rob
);

  import ooo_types_pkg::*;

  fu_kind_t [`NUM_RS-1:0]    entry_kind;   // Fixed binding
  logic     [`NUM_RS-1:0]    busy;
  logic     [`NUM_RS-1:0]    rdy1;
  logic     [`NUM_RS-1:0]    rdy2;
  pr_tag_t  [`NUM_RS-1:0]    entry_src1;
  pr_tag_t  [`NUM_RS-1:0]    entry_src2;
  logic     [`NUM_RS-1:0]    wake1;        // CDB hit on src1
  logic     [`NUM_RS-1:0]    wake2;        // CDB hit on src2
  logic     [`NUM_RS-1:0]    squash;
  rob_idx_t [`NUM_RS-1:0]    rb_dist;      // Distance from rollback index
  rs_idx_t  [`NUM_SUPER-1:0] slot_idx;     // Free entry per slot

  assign entry_kind = `RS_KIND_LIST;

  // Slot i searches entries i, i+NUM_SUPER, ... for a free entry of its kind
  always_comb begin
    for (int i = 0; i < `NUM_SUPER; i++) begin
      slot_hit[i] = 1'b0;
      slot_idx[i] = '0;
      for (int j = 0; j < `NUM_RS; j++) begin
        if ((j % `NUM_SUPER) == i && !slot_hit[i] && !busy[j] &&
            entry_kind[j] == disp_kind[i]) begin
          slot_hit[i] = 1'b1;  // Lowest free entry wins
          slot_idx[i] = rs_idx_t'(j);
        end
      end
    end
  end

  always_comb begin
    for (int j = 0; j < `NUM_RS; j++) begin
      wake1[j] = 1'b0;
      wake2[j] = 1'b0;
      for (int c = 0; c < `NUM_SUPER; c++) begin
        if (complete_en[c] && complete_tag[c] != ZERO_TAG) begin
          if (complete_tag[c] == entry_src1[j])
            wake1[j] = 1'b1;
          if (complete_tag[c] == entry_src2[j])
            wake2[j] = 1'b1;
        end
      end
    end
  end

  // Span check is modulo NUM_ROB through the wrapped subtraction
  always_comb begin
    for (int j = 0; j < `NUM_RS; j++) begin
      rb_dist[j] = entry_rob[j] - rollback_rob;
      squash[j]  = busy[j] && rollback_en && (rb_dist[j] <= rollback_span);
    end
  end

  // Registered ready bits, so wakeup shows up one cycle later
  assign entry_eligible = busy & rdy1 & rdy2 & ~squash;

  always_ff @(posedge clock) begin
    if (reset) begin
      busy <= '0;
      rdy1 <= '0;
      rdy2 <= '0;
    end else begin
      for (int j = 0; j < `NUM_RS; j++) begin
        rdy1[j] <= rdy1[j] | wake1[j];
        rdy2[j] <= rdy2[j] | wake2[j];
        if (pick_mask[j] || squash[j])
          busy[j] <= 1'b0;  // Leaves on issue or squash
      end
      if (dispatch_fire) begin
        for (int i = 0; i < `NUM_SUPER; i++) begin
          busy[slot_idx[i]] <= 1'b1;
          rdy1[slot_idx[i]] <= src1_ready[i];  // Bypassed by scoreboard
          rdy2[slot_idx[i]] <= src2_ready[i];
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (dispatch_fire) begin
      for (int i = 0; i < `NUM_SUPER; i++) begin
        entry_func[slot_idx[i]] <= disp_func[i];
        entry_dest[slot_idx[i]] <= disp_dest[i];
        entry_src1[slot_idx[i]] <= disp_src1[i];
        entry_src2[slot_idx[i]] <= disp_src2[i];
        entry_rob[slot_idx[i]]  <= disp_rob[i];
      end
    end
  end

  // The arbiter may only take entries this station offers
  pick_only_eligible: assert property (@(posedge clock) disable iff (reset)
    (pick_mask & ~entry_eligible) == '0);

endmodule

//--- logic/issue_arbiter.sv
`timescale 1ns/1ps
`include "ooo_settings.svh"

module issue_arbiter (
  input  logic                                      clock,
  input  logic                                      reset,
  input  logic                    [`NUM_RS-1:0]     entry_eligible,
  input  ooo_types_pkg::rob_idx_t [`NUM_RS-1:0]     entry_rob,
  input  ooo_types_pkg::func_t    [`NUM_RS-1:0]     entry_func,
  input  ooo_types_pkg::pr_tag_t  [`NUM_RS-1:0]     entry_dest,
  input  ooo_types_pkg::rob_idx_t                   rob_head,
  output logic                    [`NUM_RS-1:0]     pick_mask,
  output logic                    [`NUM_ISSUE-1:0]  issue_valid,
  output ooo_types_pkg::func_t    [`NUM_ISSUE-1:0]  issue_func,
  output ooo_types_pkg::pr_tag_t  [`NUM_ISSUE-1:0]  issue_dest,
  output ooo_types_pkg::rob_idx_t [`NUM_ISSUE-1:0]  issue_rob
);

  import ooo_types_pkg::*;

  rob_idx_t [`NUM_RS-1:0]    entry_age;  // Distance from ROB head
  logic     [`NUM_ISSUE-1:0] port_hit;
  rs_idx_t  [`NUM_ISSUE-1:0] port_idx;

  always_comb begin
    for (int j = 0; j < `NUM_RS; j++)
      entry_age[j] = entry_rob[j] - rob_head;
  end

  // Port 0 takes the oldest, port 1 the oldest of the rest.
  // Strict compare keeps the lower index on a tie.
  always_comb begin : select
    rob_idx_t best_age;
    pick_mask = '0;
    best_age  = '0;
    for (int p = 0; p < `NUM_ISSUE; p++) begin
      port_hit[p] = 1'b0;
      port_idx[p] = '0;
      best_age    = '0;
      for (int j = 0; j < `NUM_RS; j++) begin
        if (entry_eligible[j] && !pick_mask[j] &&
            (!port_hit[p] || entry_age[j] < best_age)) begin
          port_hit[p] = 1'b1;
          port_idx[p] = rs_idx_t'(j);
          best_age    = entry_age[j];
        end
      end
      if (port_hit[p])
        pick_mask[port_idx[p]] = 1'b1;  // Not offered to later ports
    end
  end

  always_ff @(posedge clock) begin
    if (reset)
      issue_valid <= '0;
    else
      issue_valid <= port_hit;
  end

  always_ff @(posedge clock) begin
    for (int p = 0; p < `NUM_ISSUE; p++) begin
      issue_func[p] <= entry_func[port_idx[p]];
      issue_dest[p] <= entry_dest[port_idx[p]];
      issue_rob[p]  <= entry_rob[port_idx[p]];
    end
  end

endmodule

//--- logic/ooo_issue_unit.sv
`timescale 1ns/1ps
`include "ooo_settings.svh"

module ooo_issue_unit (
  input  logic                                      clock,
  input  logic                                      reset,
  input  logic                                      dispatch_req,
  input  ooo_types_pkg::fu_kind_t [`NUM_SUPER-1:0]  disp_kind,
  input  ooo_types_pkg::func_t    [`NUM_SUPER-1:0]  disp_func,
  input  ooo_types_pkg::pr_tag_t  [`NUM_SUPER-1:0]  disp_dest,
  input  ooo_types_pkg::pr_tag_t  [`NUM_SUPER-1:0]  disp_src1,
  input  ooo_types_pkg::pr_tag_t  [`NUM_SUPER-1:0]  disp_src2,
  input  ooo_types_pkg::rob_idx_t [`NUM_SUPER-1:0]  disp_rob,
  input  logic                    [`NUM_SUPER-1:0]  complete_en,
  input  ooo_types_pkg::pr_tag_t  [`NUM_SUPER-1:0]  complete_tag,
  input  logic                                      rollback_en,
  input  ooo_types_pkg::rob_idx_t                   rollback_rob,
  input  ooo_types_pkg::rob_idx_t                   rollback_span,
  input  ooo_types_pkg::rob_idx_t                   rob_head,
  output logic                                      dispatch_ack,
  output logic                    [`NUM_ISSUE-1:0]  issue_valid,
  output ooo_types_pkg::func_t    [`NUM_ISSUE-1:0]  issue_func,
  output ooo_types_pkg::pr_tag_t  [`NUM_ISSUE-1:0]  issue_dest,
  output ooo_types_pkg::rob_idx_t [`NUM_ISSUE-1:0]  issue_rob
);

  import ooo_types_pkg::*;

  logic     [`NUM_SUPER-1:0] slot_hit;
  logic     [`NUM_SUPER-1:0] src1_ready;
  logic     [`NUM_SUPER-1:0] src2_ready;
  logic     [`NUM_RS-1:0]    entry_eligible;
  logic     [`NUM_RS-1:0]    pick_mask;
  func_t    [`NUM_RS-1:0]    entry_func;
  pr_tag_t  [`NUM_RS-1:0]    entry_dest;
  rob_idx_t [`NUM_RS-1:0]    entry_rob;

  // The ack doubles as the dispatch strobe
  dispatch_ctrl u_ctrl (
    .clock, .reset, .dispatch_req, .slot_hit, .rollback_en,
    .dispatch_fire (dispatch_ack)
  );

  tag_scoreboard u_scoreboard (
    .clock, .reset,
    .dispatch_fire (dispatch_ack),
    .disp_dest, .disp_src1, .disp_src2,
    .complete_en, .complete_tag,
    .src1_ready, .src2_ready
  );

  rs_station u_station (
    .clock, .reset,
    .dispatch_fire (dispatch_ack),
    .disp_kind, .disp_func, .disp_dest, .disp_src1, .disp_src2, .disp_rob,
    .src1_ready, .src2_ready, .complete_en, .complete_tag,
    .rollback_en, .rollback_rob, .rollback_span, .pick_mask,
    .slot_hit, .entry_eligible, .entry_func, .entry_dest, .entry_rob
  );

  issue_arbiter u_arbiter (
    .clock, .reset, .entry_eligible, .entry_rob, .entry_func, .entry_dest, .rob_head,
    .pick_mask, .issue_valid, .issue_func, .issue_dest, .issue_rob
  );

endmodule

//--- sim/issue_model.svh
`ifndef ISSUE_MODEL_SVH
`define ISSUE_MODEL_SVH

localparam int MAX_INSTR = 4096;

// One record per accepted instruction, indexed by dispatch order
fu_kind_t ins_kind      [MAX_INSTR];
func_t    ins_func      [MAX_INSTR];
pr_tag_t  ins_dest      [MAX_INSTR];
pr_tag_t  ins_src1      [MAX_INSTR];
pr_tag_t  ins_src2      [MAX_INSTR];
int       ins_lane      [MAX_INSTR];
bit       ins_rdy1      [MAX_INSTR];
bit       ins_rdy2      [MAX_INSTR];
int       ins_ready_cyc [MAX_INSTR];  // Cycle the last operand arrived
bit       ins_issued    [MAX_INSTR];
bit       ins_squashed  [MAX_INSTR];
bit       ins_late      [MAX_INSTR];
int       n_acc;                      // Accepted so far
int       head_seq;                   // Oldest waiting instruction

bit tag_done    [`NUM_PR];  // Value available
bit tag_busy    [`NUM_PR];  // Producer dispatched, not completed
bit tag_written [`NUM_PR];
bit tag_owed    [`NUM_PR];  // Producer left the station, completion due
int lane_used   [`NUM_SUPER][4];

function automatic rob_idx_t rob_of(int s);
  return rob_idx_t'(s % `NUM_ROB);
endfunction

// Each lane holds two ALU entries, one MUL and one MEM
function automatic int lane_capacity(fu_kind_t kind);
  if (kind == FU_ALU)
    return 2;
  if (kind == FU_MUL || kind == FU_MEM)
    return 1;
  return 0;
endfunction

function automatic bit lane_has_room(int lane, fu_kind_t kind);
  return lane_used[lane][kind] < lane_capacity(kind);
endfunction

function automatic bit is_waiting(int s);
  return !ins_issued[s] && !ins_squashed[s];
endfunction

task automatic record_dispatch(input int lane, input int cyc);
  int s;
  s = n_acc;
  ins_kind[s]      = disp_kind[lane];
  ins_func[s]      = disp_func[lane];
  ins_dest[s]      = disp_dest[lane];
  ins_src1[s]      = disp_src1[lane];
  ins_src2[s]      = disp_src2[lane];
  ins_lane[s]      = lane;
  ins_rdy1[s]      = (disp_src1[lane] == '0) || tag_done[disp_src1[lane]];
  ins_rdy2[s]      = (disp_src2[lane] == '0) || tag_done[disp_src2[lane]];
  ins_ready_cyc[s] = cyc;
  ins_issued[s]    = 0;
  ins_squashed[s]  = 0;
  ins_late[s]      = 0;
  lane_used[lane][disp_kind[lane]]++;
  tag_done[disp_dest[lane]]    = 0;  // Slot 1 sees slot 0 as older
  tag_busy[disp_dest[lane]]    = 1;
  tag_written[disp_dest[lane]] = 1;
  n_acc++;
endtask

task automatic complete_in_model(input pr_tag_t t, input int cyc);
  tag_done[t] = 1;
  tag_busy[t] = 0;
  tag_owed[t] = 0;
  for (int s = head_seq; s < n_acc; s++) begin
    if (is_waiting(s) && ins_src1[s] == t && !ins_rdy1[s]) begin
      ins_rdy1[s]      = 1;
      ins_ready_cyc[s] = cyc;
    end
    if (is_waiting(s) && ins_src2[s] == t && !ins_rdy2[s]) begin
      ins_rdy2[s]      = 1;
      ins_ready_cyc[s] = cyc;
    end
  end
endtask

task automatic leave_station(input int s);
  lane_used[ins_lane[s]][ins_kind[s]]--;
  tag_owed[ins_dest[s]] = 1;
endtask

task automatic squash_span(input rob_idx_t rb_rob, input rob_idx_t span);
  for (int s = head_seq; s < n_acc; s++) begin
    if (is_waiting(s) && rob_idx_t'(rob_of(s) - rb_rob) <= span) begin
      ins_squashed[s] = 1;
      leave_station(s);
    end
  end
endtask

task automatic advance_head();
  while (head_seq < n_acc && !is_waiting(head_seq))
    head_seq++;
endtask

// Waiting instructions span fewer than NUM_ROB slots, so the match is unique
function automatic int find_recent(rob_idx_t rob);
  for (int s = n_acc - 1; s >= 0 && s >= n_acc - `NUM_ROB; s--) begin
    if (rob_of(s) == rob)
      return s;
  end
  return -1;
endfunction

`endif

//--- sim/ooo_issue_unit_tb.sv
`timescale 1ns/1ps
`include "ooo_settings.svh"

module ooo_issue_unit_tb;

  import ooo_types_pkg::*;

  localparam int RUN_CYCLES  = 1500;
  localparam int DRAIN_LIMIT = 400;
  localparam int ISSUE_LIMIT = 40;  // Cycles from ready operands to issue

  logic                               clock;
  logic                               reset;
  logic                               dispatch_req;
  fu_kind_t [`NUM_SUPER-1:0]          disp_kind;
  func_t    [`NUM_SUPER-1:0]          disp_func;
  pr_tag_t  [`NUM_SUPER-1:0]          disp_dest;
  pr_tag_t  [`NUM_SUPER-1:0]          disp_src1;
  pr_tag_t  [`NUM_SUPER-1:0]          disp_src2;
  rob_idx_t [`NUM_SUPER-1:0]          disp_rob;
  logic     [`NUM_SUPER-1:0]          complete_en;
  pr_tag_t  [`NUM_SUPER-1:0]          complete_tag;
  logic                               rollback_en;
  rob_idx_t                           rollback_rob;
  rob_idx_t                           rollback_span;
  rob_idx_t                           rob_head;
  logic                               dispatch_ack;
  logic     [`NUM_ISSUE-1:0]          issue_valid;
  func_t    [`NUM_ISSUE-1:0]          issue_func;
  pr_tag_t  [`NUM_ISSUE-1:0]          issue_dest;
  rob_idx_t [`NUM_ISSUE-1:0]          issue_rob;

  `include "issue_model.svh"

  logic [31:0] lfsr_state;
  int          cycle;
  bit          req_hold;   // Group waits for its ack
  bit          rb_prev;
  string       test_name [5];
  int          chk [5];
  int          err [5];
  int          waited;
  int          total_err;

  ooo_issue_unit uut (.*);

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  // Taps 32, 22, 2, 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
      v = {v[30:0], lfsr_bit()};
    return v;
  endfunction

  task automatic check_value(input int t, input string what,
                             input logic [31:0] exp, input logic [31:0] act);
    chk[t]++;
    assert (exp == act) else begin
      $display("** Error %s %s: expected %0h actual %0h", test_name[t], what, exp, act);
      err[t]++;
    end
  endtask

  task automatic check_true(input int t, input bit ok, input string what);
    chk[t]++;
    assert (ok) else begin
      $display("** Error %s: %s", test_name[t], what);
      err[t]++;
    end
  endtask

  function automatic int pick_free_dest(int start, int avoid);
    int t;
    for (int i = 0; i < `NUM_PR; i++) begin
      t = (start + i) % `NUM_PR;
      if (t != 0 && t != avoid && !tag_busy[t] && !tag_owed[t])
        return t;
    end
    return 0;
  endfunction

  function automatic pr_tag_t pick_source();
    pr_tag_t t;
    t = pr_tag_t'(rand_bits(5));
    return tag_written[t] ? t : '0;  // Never written reads the zero register
  endfunction

  function automatic bit build_group();
    int t;
    if (n_acc + 2 - head_seq > `NUM_ROB || n_acc >= MAX_INSTR - 2)
      return 0;
    for (int s = 0; s < `NUM_SUPER; s++) begin
      t = pick_free_dest(int'(rand_bits(5)), s == 1 ? int'(disp_dest[0]) : 0);
      if (t == 0)
        return 0;
      disp_kind[s] = fu_kind_t'(rand_bits(2) % 3);
      disp_func[s] = func_t'(rand_bits(4));
      disp_dest[s] = pr_tag_t'(t);
      disp_src1[s] = pick_source();
      disp_src2[s] = pick_source();
      disp_rob[s]  = rob_of(n_acc + s);
    end
    return 1;
  endfunction

  task automatic drive_completions();
    int t;
    int idx;
    complete_en  = '0;
    complete_tag = '0;
    for (int c = 0; c < `NUM_SUPER; c++) begin
      if (rand_bits(1) == 1) begin
        t = 0;
        for (int i = 0; i < `NUM_PR && t == 0; i++) begin
          idx = (int'(rand_bits(5)) + i) % `NUM_PR;
          if (tag_owed[idx])
            t = idx;
        end
        if (t != 0 && tag_owed[t]) begin
          complete_en[c]  = 1'b1;
          complete_tag[c] = pr_tag_t'(t);
          complete_in_model(pr_tag_t'(t), cycle);  // Clears owed, so ports differ
        end
      end
    end
  endtask

  task automatic observe_issue();
    int s;
    if (issue_valid[0] && issue_valid[1])
      check_true(3, rob_idx_t'(issue_rob[0] - rob_head) < rob_idx_t'(issue_rob[1] - rob_head),
                 $sformatf("port 1 ROB %0d older than port 0 ROB %0d", issue_rob[1], issue_rob[0]));
    for (int p = 0; p < `NUM_ISSUE; p++) begin
      if (issue_valid[p]) begin
        s = find_recent(issue_rob[p]);
        check_true(1, s >= 0, $sformatf("issue of unknown ROB %0d", issue_rob[p]));
        if (s >= 0) begin
          check_true(4, !ins_squashed[s], $sformatf("ROB %0d issued after rollback", issue_rob[p]));
          check_true(2, !ins_issued[s], $sformatf("ROB %0d issued twice", issue_rob[p]));
          check_value(1, "func", 32'(ins_func[s]), 32'(issue_func[p]));
          check_value(1, "dest", 32'(ins_dest[s]), 32'(issue_dest[p]));
          check_true(1, ins_rdy1[s] && ins_rdy2[s] && cycle >= ins_ready_cyc[s] + 2,
                     $sformatf("ROB %0d issued before its operands were ready", issue_rob[p]));
          if (is_waiting(s)) begin
            ins_issued[s] = 1;
            leave_station(s);
          end
        end
      end
    end
  endtask

  task automatic check_stalls();
    for (int s = head_seq; s < n_acc; s++) begin
      if (is_waiting(s) && !ins_late[s] && ins_rdy1[s] && ins_rdy2[s] &&
          cycle - ins_ready_cyc[s] > ISSUE_LIMIT) begin
        ins_late[s] = 1;
        check_true(2, 1'b0, $sformatf("ROB %0d not issued within %0d cycles of ready operands",
                                      rob_of(s), ISSUE_LIMIT));
      end
    end
  endtask

  // Observe last edge, drive this cycle, then read the settled ack
  task automatic run_cycle(input bit allow_new, input bit allow_rb);
    bit rb_now;
    bit exp_ack;
    @(negedge clock);
    cycle++;
    observe_issue();
    advance_head();
    check_stalls();
    rollback_en = 1'b0;
    rb_now      = 0;
    drive_completions();
    if (!req_hold) begin
      dispatch_req = 1'b0;
      if (allow_new && rand_bits(2) != 0 && build_group()) begin
        dispatch_req = 1'b1;
        req_hold     = 1;
      end
    end
    if (allow_rb && head_seq < n_acc && rand_bits(4) == 0) begin
      rollback_rob  = rob_of(head_seq + int'(rand_bits(4)) % (n_acc - head_seq));
      rollback_span = rob_idx_t'(rand_bits(2));
      rollback_en   = 1'b1;
      rb_now        = 1;
    end
    rob_head = rob_of(head_seq);
    #1;
    exp_ack = dispatch_req && lane_has_room(0, disp_kind[0]) &&
              lane_has_room(1, disp_kind[1]) && !rb_now && !rb_prev;
    check_value(0, "dispatch_ack", 32'(exp_ack), 32'(dispatch_ack));
    if (dispatch_ack) begin
      record_dispatch(0, cycle);
      record_dispatch(1, cycle);
      req_hold = 0;
    end
    if (rb_now)
      squash_span(rollback_rob, rollback_span);
    rb_prev = rb_now;
  endtask

  initial begin
    reset         = 1'b1;
    dispatch_req  = 1'b0;
    disp_kind     = '0;
    disp_func     = '0;
    disp_dest     = '0;
    disp_src1     = '0;
    disp_src2     = '0;
    disp_rob      = '0;
    complete_en   = '0;
    complete_tag  = '0;
    rollback_en   = 1'b0;
    rollback_rob  = '0;
    rollback_span = '0;
    rob_head      = '0;
    lfsr_state    = 32'h3de3fab3;
    test_name     = '{"dispatch", "wakeup", "completeness", "age_order", "rollback"};
    chk           = '{default: 0};
    err           = '{default: 0};
    n_acc         = 0;
    head_seq      = 0;
    cycle         = 0;
    req_hold      = 0;
    rb_prev       = 0;
    for (int t = 0; t < `NUM_PR; t++) begin
      tag_done[t]    = 1;  // All tags ready after reset
      tag_busy[t]    = 0;
      tag_written[t] = 0;
      tag_owed[t]    = 0;
    end
    lane_used = '{default: '{default: 0}};

    repeat (2) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    repeat (2) @(negedge clock);  // Controller leaves its init state

    for (int i = 0; i < RUN_CYCLES; i++)
      run_cycle(1, 1);
    waited = 0;
    while ((head_seq < n_acc || req_hold) && waited < DRAIN_LIMIT) begin
      run_cycle(0, 0);
      waited++;
    end

    if (head_seq < n_acc || req_hold) begin
      $display("Timeout: %0d instructions still waiting after %0d drain cycles",
               n_acc - head_seq, DRAIN_LIMIT);
      $display("sim failed");
      $finish;
    end else begin
      for (int i = 0; i < 4; i++)
        run_cycle(0, 0);  // A repeated issue shows up here
      total_err = 0;
      for (int t = 0; t < 5; t++) begin
        $display("%-12s checks %0d errors %0d", test_name[t], chk[t], err[t]);
        total_err += err[t];
      end
      $display("instructions %0d checks %0d errors %0d", n_acc,
               chk[0] + chk[1] + chk[2] + chk[3] + chk[4], total_err);
      if (total_err == 0)
        $display("sim passed");
      else
        $display("sim failed");
      $finish;
    end
  end

endmodule

//--- list.f
+incdir+common
+incdir+sim
common/ooo_types_pkg.sv
common/ooo_ctrl_pkg.sv
logic/dispatch_ctrl.sv
logic/tag_scoreboard.sv
rs/rs_station.sv
logic/issue_arbiter.sv
logic/ooo_issue_unit.sv
sim/ooo_issue_unit_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= ooo_issue_unit_tb
RTL_TOP   ?= ooo_issue_unit
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILE_LIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "sim failed" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "sim passed" $(LOG); then echo "FAIL: no result line"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
